// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_machine_core
FILELIST  = all.f
OBJ_DIR   = obj_dir
PASS_MSG  = sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
logic/machine_pkg.sv
logic/phase_sequencer.sv
logic/program_counter.sv
logic/insn_decoder.sv
logic/alu_exec.sv
logic/register_file.sv
logic/machine_core.sv
verification/tb_machine_core.sv

// ==== logic/alu_exec.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_exec (
    input  wire                clk,
    input  wire                reset_n,
    input  wire                i_exec_en,
    input  wire                i_type,
    input  wire machine_pkg::op_t   i_op,
    input  wire machine_pkg::word_t i_x,
    input  wire machine_pkg::word_t i_y,
    input  wire machine_pkg::imm_t  i_imm,
    output machine_pkg::word_t o_rhs
);

    machine_pkg::word_t imm_ext;
    machine_pkg::word_t operand;
    machine_pkg::word_t addend;
    machine_pkg::word_t result;
    logic [4:0]         shamt;

    assign imm_ext = {{20{i_imm[11]}}, i_imm};

    // Type 1 swaps the immediate and Y
    assign operand = i_type ? imm_ext : i_y;
    assign addend  = i_type ? i_y : imm_ext;
    assign shamt   = operand[4:0];

    always_comb begin
        case (i_op)
            machine_pkg::OP_OR:   result = i_x | operand;
            machine_pkg::OP_AND:  result = i_x & operand;
            machine_pkg::OP_ADD:  result = i_x + operand;
            machine_pkg::OP_MUL:  result = i_x * operand;
            machine_pkg::OP_SHL:  result = i_x << shamt;
            machine_pkg::OP_LT:   result = {32{$signed(i_x) < $signed(operand)}};
            machine_pkg::OP_EQ:   result = {32{i_x == operand}};
            machine_pkg::OP_GT:   result = {32{$signed(i_x) > $signed(operand)}};
            machine_pkg::OP_ANDN: result = i_x & ~operand;
            machine_pkg::OP_XOR:  result = i_x ^ operand;
            machine_pkg::OP_SUB:  result = i_x - operand;
            machine_pkg::OP_XNOR: result = i_x ^ ~operand;
            machine_pkg::OP_SHR:  result = i_x >> shamt;   // Logical
            machine_pkg::OP_NE:   result = {32{i_x != operand}};
            default:              result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_exec_en) begin
            o_rhs <= result + addend;
        end
    end

    // Reserved opcodes must have halted the core in DECODE
    assert property (@(posedge clk) disable iff (!reset_n)
        i_exec_en |-> (i_op != machine_pkg::OP_RSVD_A) && (i_op != machine_pkg::OP_RSVD_B))
        else $error("reserved opcode reached execute");

endmodule

`default_nettype wire

// ==== logic/insn_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module insn_decoder (
    input  wire                clk,
    input  wire                reset_n,
    input  wire                i_latch,
    input  wire machine_pkg::word_t i_insn_data,
    output machine_pkg::reg_index_t o_idx_z,
    output machine_pkg::reg_index_t o_idx_x,
    output machine_pkg::reg_index_t o_idx_y,
    output machine_pkg::imm_t   o_imm,
    output machine_pkg::op_t    o_op,
    output machine_pkg::deref_t o_deref,
    output logic               o_type,
    output logic               o_illegal
);

    machine_pkg::word_t insn_q;
    machine_pkg::op_t   raw_op;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            insn_q <= '0;
        end else if (i_latch) begin
            insn_q <= i_insn_data;
        end
    end

    // Field slicing
    assign o_type  = insn_q[30];
    assign o_deref = insn_q[29:28];
    assign o_idx_z = insn_q[27:24];
    assign o_idx_x = insn_q[23:20];
    assign o_idx_y = insn_q[19:16];
    assign o_op    = insn_q[15:12];
    assign o_imm   = insn_q[11:0];

    // Checked on the raw word so the sequencer can branch out of DECODE
    assign raw_op = i_insn_data[15:12];

    assign o_illegal = i_latch && ((&i_insn_data)
                                   || i_insn_data[31]      // Class 1 not supported
                                   || (raw_op == machine_pkg::OP_RSVD_A)
                                   || (raw_op == machine_pkg::OP_RSVD_B));

endmodule

`default_nettype wire

// ==== logic/machine_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module machine_core #(
    parameter machine_pkg::word_t RESET_VECTOR = '0
) (
    input  wire                     clk,
    input  wire                     reset_n,
    input  wire machine_pkg::word_t i_insn_data,
    input  wire machine_pkg::word_t i_data_rdata,
    output machine_pkg::word_t      o_insn_addr,
    output machine_pkg::word_t      o_data_addr,
    output machine_pkg::word_t      o_data_wdata,
    output logic                    o_data_we,
    output logic                    o_halt
);

    logic latch_insn, exec_en, mem_en, wb_en;
    logic insn_illegal, insn_type;
    logic z_writes, reg_we, jump;

    machine_pkg::reg_index_t idx_z, idx_x, idx_y;
    machine_pkg::imm_t       imm;
    machine_pkg::op_t        op;
    machine_pkg::deref_t     deref;
    machine_pkg::word_t      pc_next, val_x, val_y, val_z, rhs, wb_value;

    phase_sequencer u_seq (
        .clk(clk), .reset_n(reset_n), .i_insn_illegal(insn_illegal),
        .o_latch_insn(latch_insn), .o_exec_en(exec_en), .o_mem_en(mem_en),
        .o_wb_en(wb_en), .o_halt(o_halt)
    );

    program_counter #(.RESET_VECTOR(RESET_VECTOR)) u_pc (
        .clk(clk), .reset_n(reset_n), .i_wb_en(wb_en), .i_jump(jump),
        .i_jump_target(wb_value), .o_pc(o_insn_addr), .o_pc_next(pc_next)
    );

    insn_decoder u_dec (
        .clk(clk), .reset_n(reset_n), .i_latch(latch_insn), .i_insn_data(i_insn_data),
        .o_idx_z(idx_z), .o_idx_x(idx_x), .o_idx_y(idx_y), .o_imm(imm), .o_op(op),
        .o_deref(deref), .o_type(insn_type), .o_illegal(insn_illegal)
    );

    alu_exec u_alu (
        .clk(clk), .reset_n(reset_n), .i_exec_en(exec_en), .i_type(insn_type),
        .i_op(op), .i_x(val_x), .i_y(val_y), .i_imm(imm), .o_rhs(rhs)
    );

    register_file u_regs (
        .clk(clk), .reset_n(reset_n), .i_idx_x(idx_x), .i_idx_y(idx_y), .i_idx_z(idx_z),
        .i_pc_next(pc_next), .i_we(reg_we), .i_wdata(wb_value),
        .o_x(val_x), .o_y(val_y), .o_z(val_z)
    );

    // Memory side of the dereference
    always_comb begin
        case (deref)
            machine_pkg::DEREF_STORE_Z: begin
                o_data_addr  = val_z;
                o_data_wdata = rhs;
            end
            machine_pkg::DEREF_STORE_RHS: begin
                o_data_addr  = rhs;
                o_data_wdata = val_z;
            end
            default: begin      // Load address, or unused for plain assign
                o_data_addr  = rhs;
                o_data_wdata = val_z;
            end
        endcase
    end

    assign o_data_we = mem_en && deref[1];  // Both store modes

    // Register side
    assign z_writes = (deref == machine_pkg::DEREF_NONE) || (deref == machine_pkg::DEREF_LOAD);
    assign wb_value = (deref == machine_pkg::DEREF_LOAD) ? i_data_rdata : rhs;
    assign reg_we   = wb_en && z_writes && (idx_z != '0) && (idx_z != machine_pkg::PC_INDEX);
    assign jump     = z_writes && (idx_z == machine_pkg::PC_INDEX);

endmodule

`default_nettype wire

// ==== logic/machine_pkg.sv ====
`default_nettype none

package machine_pkg;

    typedef logic [31:0] word_t;       // Data, address and instruction word
    typedef logic [3:0]  reg_index_t;  // Register number
    typedef logic [11:0] imm_t;        // Raw immediate field
    typedef logic [3:0]  op_t;         // ALU operation
    typedef logic [1:0]  deref_t;      // Memory dereference mode

    // ALU operation codes
    localparam op_t OP_OR     = 4'd0;
    localparam op_t OP_AND    = 4'd1;
    localparam op_t OP_ADD    = 4'd2;
    localparam op_t OP_MUL    = 4'd3;
    localparam op_t OP_RSVD_A = 4'd4;
    localparam op_t OP_SHL    = 4'd5;
    localparam op_t OP_LT     = 4'd6;
    localparam op_t OP_EQ     = 4'd7;
    localparam op_t OP_GT     = 4'd8;
    localparam op_t OP_ANDN   = 4'd9;
    localparam op_t OP_XOR    = 4'd10;
    localparam op_t OP_SUB    = 4'd11;
    localparam op_t OP_XNOR   = 4'd12;
    localparam op_t OP_SHR    = 4'd13;
    localparam op_t OP_NE     = 4'd14;
    localparam op_t OP_RSVD_B = 4'd15;

    localparam deref_t DEREF_NONE      = 2'b00; //  Z  <-  rhs
    localparam deref_t DEREF_LOAD      = 2'b01; //  Z  <- [rhs]
    localparam deref_t DEREF_STORE_Z   = 2'b10; // [Z] <-  rhs
    localparam deref_t DEREF_STORE_RHS = 2'b11; // [rhs] <- Z

    localparam reg_index_t PC_INDEX = 4'd15;

endpackage

`default_nettype wire

// ==== logic/phase_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module phase_sequencer (
    input  wire  clk,
    input  wire  reset_n,
    input  wire  i_insn_illegal,
    output logic o_latch_insn,
    output logic o_exec_en,
    output logic o_mem_en,
    output logic o_wb_en,
    output logic o_halt
);

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALTED
    } phase_t;

    phase_t state;
    phase_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            FETCH:     state_next = DECODE;
            DECODE:    state_next = i_insn_illegal ? HALTED : EXECUTE;
            EXECUTE:   state_next = MEMORY;
            MEMORY:    state_next = WRITEBACK;
            WRITEBACK: state_next = FETCH;
            default:   state_next = HALTED; // Stuck until reset
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= FETCH;
        end else begin
            state <= state_next;
        end
    end

    assign o_latch_insn = (state == DECODE);
    assign o_exec_en    = (state == EXECUTE);
    assign o_mem_en     = (state == MEMORY);
    assign o_wb_en      = (state == WRITEBACK);
    assign o_halt       = (state == HALTED);

    // Branch out of DECODE needs a known flag
    assert property (@(posedge clk) disable iff (!reset_n)
        o_latch_insn |-> !$isunknown(i_insn_illegal))
        else $error("illegal flag unknown in decode");

endmodule

`default_nettype wire

// ==== logic/program_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module program_counter #(
    parameter machine_pkg::word_t RESET_VECTOR = '0
) (
    input  wire                clk,
    input  wire                reset_n,
    input  wire                i_wb_en,
    input  wire                i_jump,
    input  wire machine_pkg::word_t i_jump_target,
    output machine_pkg::word_t o_pc,
    output machine_pkg::word_t o_pc_next
);

    // Successor of a word address is one up
    assign o_pc_next = o_pc + 32'd1;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            o_pc <= RESET_VECTOR;
        end else if (i_wb_en) begin
            o_pc <= i_jump ? i_jump_target : o_pc_next;
        end
    end

    // One advance per instruction
    assert property (@(posedge clk) disable iff (!reset_n)
        i_wb_en |=> !i_wb_en)
        else $error("writeback strobe held past one cycle");

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  wire                     clk,
    input  wire                     reset_n,
    input  wire machine_pkg::reg_index_t i_idx_x,
    input  wire machine_pkg::reg_index_t i_idx_y,
    input  wire machine_pkg::reg_index_t i_idx_z,
    input  wire machine_pkg::word_t i_pc_next,
    input  wire                     i_we,
    input  wire machine_pkg::word_t i_wdata,
    output machine_pkg::word_t      o_x,
    output machine_pkg::word_t      o_y,
    output machine_pkg::word_t      o_z
);

    machine_pkg::word_t regs [1:14];  // r0 and the pc are not stored here
    logic               z_stored;

    assign z_stored = (i_idx_z != '0) && (i_idx_z != machine_pkg::PC_INDEX);

    always_ff @(posedge clk) begin
        if (i_we && z_stored) begin
            regs[i_idx_z] <= i_wdata;
        end
    end

    // Read ports
    assign o_x = (i_idx_x == '0) ? '0
               : (i_idx_x == machine_pkg::PC_INDEX) ? i_pc_next
               : regs[i_idx_x];

    assign o_y = (i_idx_y == '0) ? '0
               : (i_idx_y == machine_pkg::PC_INDEX) ? i_pc_next
               : regs[i_idx_y];

    assign o_z = (i_idx_z == '0) ? '0
               : (i_idx_z == machine_pkg::PC_INDEX) ? i_pc_next
               : regs[i_idx_z];

    // Top level filters out writes to r0
    assert property (@(posedge clk) disable iff (!reset_n)
        i_we |-> (i_idx_z != '0))
        else $error("register write aimed at r0");

endmodule

`default_nettype wire

// ==== verification/core_trace.txt ====
# P addr word = program word, D addr word = initial data word
# E test addr data = expected store in order, T test = end of that test
D 40 FFFFFFF0
D 41 00000003
D 42 5A5A1234
P 00 11000040
P 01 12000041
P 02 03000080
P 03 23120000
P 04 23131000
P 05 23122005
P 06 23123000
P 07 23125000
P 08 23126000
P 09 23117000
P 0A 23218000
P 0B 23129000
P 0C 2312A000
P 0D 2312B000
P 0E 2312C000
P 0F 2312D000
P 10 2322E00C
E alu 80 FFFFFFF3
E alu 80 00000080
E alu 80 FFFFFFF8
E alu 80 FFFFFFD0
E alu 80 FFFFFF80
E alu 80 FFFFFFFF
E alu 80 FFFFFFFF
E alu 80 FFFFFFFF
E alu 80 FFFFFFF0
E alu 80 FFFFFFF3
E alu 80 FFFFFFED
E alu 80 0000000C
E alu 80 1FFFFFFE
E alu 80 0000000C
T alu
P 11 63212FFE
P 12 6312B800
P 13 63205004
E type1 80 FFFFFFF1
E type1 80 000007F3
E type1 80 00000030
T type1
P 14 31000090
P 15 23202010
P 16 14000042
P 17 34000091
P 18 15300FC2
P 19 35000092
E load_store 90 FFFFFFF0
E load_store 80 00000013
E load_store 91 5A5A1234
E load_store 92 5A5A1234
T load_store
P 1A 00000777
P 1B 10000040
P 1C 300000A0
P 1D 23002005
E r0 A0 00000000
E r0 80 00000005
T r0
P 1E 23F00000
P 1F 0F000022
P 20 300000B0
P 21 300000B0
P 22 320000B1
P 23 0FF02001
P 24 300000B2
P 25 310000B3
E pc 80 0000001F
E pc B1 00000003
E pc B3 FFFFFFF0
T pc
P 26 FFFFFFFF
P 27 310000C0
T halt

// ==== verification/tb_machine_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_machine_core;

    localparam string TRACE_FILE = "verification/core_trace.txt";
    localparam int    HALT_DWELL = 20;  // Cycles watched after the halt

    logic        clk;
    logic        reset_n;
    logic [31:0] insn_data;
    logic [31:0] data_rdata;
    logic [31:0] insn_addr;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic        data_we;
    logic        halt;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];

    // Expected events in trace order, a set end flag marks a test boundary
    bit           ev_end  [$];
    logic [127:0] ev_name [$];
    logic [31:0]  ev_addr [$];
    logic [31:0]  ev_data [$];

    int          n_prog     = 0;
    int          n_pass     = 0;
    int          n_fail     = 0;
    int          n_errors   = 0;
    int          test_errs  = 0;
    int          cycles     = 0;
    int          limit      = 0;
    int          halt_cycle = 0;
    bit          halt_seen  = 1'b0;
    bit          timed_out  = 1'b0;
    bit          finished   = 1'b0;
    logic [31:0] halt_addr  = 32'hFFFF_FFFF;

    machine_core #(.RESET_VECTOR(32'h0)) UUT (
        .clk(clk), .reset_n(reset_n), .i_insn_data(insn_data), .i_data_rdata(data_rdata),
        .o_insn_addr(insn_addr), .o_data_addr(data_addr), .o_data_wdata(data_wdata),
        .o_data_we(data_we), .o_halt(halt)
    );

    always #10 clk = ~clk;

    task automatic count_error();
        test_errs++;
        n_errors++;
    endtask

    task automatic pop_event();
        ev_end.delete(0);
        ev_name.delete(0);
        ev_addr.delete(0);
        ev_data.delete(0);
    endtask

    // Closes the test whose end marker heads the queue
    task automatic finish_test();
        if (test_errs == 0) begin
            $display("test %0s: pass", ev_name[0]);
            n_pass++;
        end else begin
            $display("test %0s: fail with %0d errors", ev_name[0], test_errs);
            n_fail++;
        end
        test_errs = 0;
        pop_event();
    endtask

    task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
        if (ev_end.size() == 0 || ev_end[0]) begin
            $display("unexpected store of %h to address %h", data, addr);
            count_error();
        end else begin
            if (addr !== ev_addr[0] || data !== ev_data[0]) begin
                $display("mismatch in test %0s: expected %h at %h, actual %h at %h",
                         ev_name[0], ev_data[0], ev_addr[0], data, addr);
                count_error();
            end
            pop_event();
            if (ev_end.size() > 0 && ev_end[0]) begin
                finish_test();
            end
        end
    endtask

    task automatic check_halt_addr();
        logic [127:0] name;
        name = (ev_name.size() > 0) ? ev_name[0] : '0;
        if (insn_addr !== halt_addr) begin
            $display("mismatch in test %0s: halt address expected %h, actual %h",
                     name, halt_addr, insn_addr);
            count_error();
        end
    endtask

    task automatic load_trace();
        int            fd;
        int            n;
        logic [7:0]    tag;
        logic [127:0]  name;
        logic [1023:0] line;
        logic [31:0]   addr;
        logic [31:0]   word;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the trace file %0s", TRACE_FILE);
            n_errors++;
        end else begin
            tag = '0;
            while ($fscanf(fd, "%s", tag) == 1) begin
                name = '0;
                if (tag == "#") begin
                    n = $fgets(line, fd);  // Column notes
                end else if (tag == "P") begin
                    n = $fscanf(fd, "%h %h", addr, word);
                    imem[addr[7:0]] = word;
                    n_prog++;
                    if (word == 32'hFFFF_FFFF) begin
                        halt_addr = addr;
                    end
                end else if (tag == "D") begin
                    n = $fscanf(fd, "%h %h", addr, word);
                    dmem[addr[7:0]] = word;
                end else if (tag == "E") begin
                    n = $fscanf(fd, "%s %h %h", name, addr, word);
                    ev_end.push_back(1'b0);
                    ev_name.push_back(name);
                    ev_addr.push_back(addr);
                    ev_data.push_back(word);
                end else if (tag == "T") begin
                    n = $fscanf(fd, "%s", name);
                    ev_end.push_back(1'b1);
                    ev_name.push_back(name);
                    ev_addr.push_back('0);
                    ev_data.push_back('0);
                end else begin
                    $display("unknown tag in the trace file");
                    n_errors++;
                end
                tag = '0;
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int junk;
        clk        = 1'b0;
        reset_n    = 1'b0;
        insn_data  = '0;
        data_rdata = '0;
        junk = $urandom(51637);
        for (int a = 0; a < 256; a++) begin
            imem[a] = 32'h8000_0000 | a;  // Class bit set, halts if ever fetched
            dmem[a] = $urandom;
        end
        load_trace();
        limit = n_prog * 5 * 4 + 200;

        while (!finished) begin
            @(posedge clk);
            cycles++;
            if (cycles == 16) begin
                reset_n <= 1'b1;
            end
            // One cycle memory latency on both ports
            insn_data  <= imem[insn_addr[7:0]];
            data_rdata <= dmem[data_addr[7:0]];
            if (reset_n && data_we) begin
                dmem[data_addr[7:0]] = data_wdata;
                check_store(data_addr, data_wdata);
            end
            if (halt && !halt_seen) begin
                halt_seen  = 1'b1;
                halt_cycle = cycles;
                check_halt_addr();
            end
            if (halt_seen && cycles >= halt_cycle + HALT_DWELL) begin
                finished = 1'b1;
            end else if (!halt_seen && cycles >= limit) begin
                timed_out = 1'b1;
                finished  = 1'b1;
            end
        end

        if (timed_out) begin
            $display("timeout: core did not halt within %0d cycles", limit);
            $display("sim failed");
        end else begin
            if (!halt) begin
                $display("core left the halted state");
                count_error();
            end
            check_halt_addr();  // Still parked on the halting word
            while (ev_end.size() > 0) begin
                if (ev_end[0]) begin
                    finish_test();
                end else begin
                    $display("test %0s: expected store of %h to %h never happened",
                             ev_name[0], ev_data[0], ev_addr[0]);
                    count_error();
                    pop_event();
                end
            end
            $display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, n_errors);
            if (n_errors == 0 && n_fail == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire
